//--- Bender.yml
package:
  name: dram_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dram_ctrl_pkg.sv
      - hdl/dram_ctrl_if.sv
      - hdl/dram_timer.sv
      - hdl/dram_sequencer.sv
      - hdl/dram_burst_path.sv
      - hdl/dram_ctrl_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - bench
    files:
      - bench/tb_dram_ctrl.sv

//--- bench/dram_tb_tasks.svh
// Testbench checks and tests
`ifndef DRAM_TB_TASKS_SVH
`define DRAM_TB_TASKS_SVH

// Galois LFSR stepped once per returned bit
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        r = {r[30:0], lfsr[0]};
    end
    return r;
endfunction

task automatic check_cmd(input dram_ctrl_pkg::dram_cmd_e got, input dram_ctrl_pkg::dram_cmd_e exp,
                         input string what);
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
endtask

task automatic check_data(input dram_ctrl_pkg::dq_t got, input dram_ctrl_pkg::dq_t exp,
                          input string what);
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_addr(input dram_ctrl_pkg::row_t got_row, input dram_ctrl_pkg::row_t exp_row,
                          input dram_ctrl_pkg::col_t got_col, input dram_ctrl_pkg::col_t exp_col,
                          input logic [4:0] got_ba, input logic [4:0] exp_ba, input string what);
    if (got_row !== exp_row || got_col !== exp_col || got_ba !== exp_ba) begin
        errors++;
        $display("[FAIL] %0t: %s got row %h col %h ba %h expected row %h col %h ba %h",
                 $time, what, got_row, got_col, got_ba, exp_row, exp_col, exp_ba);
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

// Keep bursts clear of the next refresh
task automatic wait_refresh_window();
    while (cyc - last_ref > `T_REFI / 2)
        @(negedge clk);
    @(posedge clk);
    #0.5;
endtask

task automatic do_write(input logic [31:0] addr, input dram_ctrl_pkg::beat_t len);
    int beat;
    awaddr  = addr;
    awlen   = len;
    awvalid = 1'b1;
    do @(negedge clk); while (!awready);
    check_bit(arready, 1'b0, "arready during write accept");
    @(posedge clk);
    #0.5;
    awvalid = 1'b0;
    beat    = 0;
    wvalid  = 1'b1;
    wdata   = random_bits(32);
    wlast   = (len == 0);
    while (beat <= len) begin
        @(negedge clk);
        if (wready) begin
            if (beat == 0)
                check_bit(cyc == cas_cyc, 1'b1, "wready one cycle after WRITE");
            exp_mem[{addr[30:0], dram_ctrl_pkg::beat_t'(beat)}] = wdata;
            @(posedge clk);
            #0.5;
            beat++;
            wdata = random_bits(32);
            wlast = (beat == len);
        end
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    @(negedge clk);
    check_bit(bvalid, 1'b1, "bvalid after wlast");
    check_bit(wready, 1'b0, "wready after wlast");
    repeat (random_bits(2)) @(negedge clk);
    @(posedge clk);
    #0.5;
    bready = 1'b1;
    do @(negedge clk); while (!bvalid);
    @(posedge clk);
    #0.5;
    bready = 1'b0;
    check_cmd(cas_cmd, dram_ctrl_pkg::CMD_WRITE, "column command");
    check_addr(act_row, addr[30:15], cas_col, addr[14:5], act_ba, addr[4:0], "write address");
endtask
`endif

//--- bench/tb_dram_ctrl.sv
// Controller testbench
`timescale 1ns/1ps
`include "dram_ctrl_cfg.svh"

module tb_dram_ctrl;
    localparam int INIT_CYC = `T_POWERUP + `T_CKE + `INIT_MRW_COUNT * `T_MRW + `T_ZQ
                              + `T_RP + `T_INIT_END;
    localparam int IDLE_CYC = 3 * `T_REFI;
    localparam int TEST_CYC = IDLE_CYC + 12 * (`T_REFI + 100);
    localparam int REF_CYC  = (INIT_CYC + TEST_CYC) / `T_REFI * `T_RFC;

    logic clk, rst_n;
    logic [`ADDR_WIDTH-1:0] awaddr, araddr;
    dram_ctrl_pkg::beat_t awlen, arlen;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;
    dram_ctrl_pkg::dq_t wdata, rdata, dq_out, dq_in;
    logic cke, cs_n, dq_oe;
    dram_ctrl_pkg::dram_cmd_e ca;
    logic [4:0] ba;
    logic [15:0] ma;

    logic [31:0] lfsr;
    int errors, cyc, last_act, last_pre, last_ref, last_take, done_cyc, ref_seen;
    int mrw_seen, pre_seen, cke_low, rd_start, wr_beat, cas_cyc;
    logic init_done, prev_w_fire;
    dram_ctrl_pkg::dq_t prev_wdata;
    dram_ctrl_pkg::dram_cmd_e cas_cmd;
    logic [4:0] act_ba;
    dram_ctrl_pkg::row_t act_row;
    dram_ctrl_pkg::col_t cas_col;
    dram_ctrl_pkg::dq_t mem [logic [34:0]];      // Device contents by ba, row, col, beat
    dram_ctrl_pkg::dq_t exp_mem [logic [34:0]];  // Expected data by address and beat

    `include "dram_tb_tasks.svh"

    dram_ctrl_top dram_ctrl_top_inst (.*);

    always #2 clk = ~clk;

    function automatic dram_ctrl_pkg::dq_t device_word(input logic [34:0] key);
        if (mem.exists(key))
            return mem[key];
        return key[31:0] ^ {key[34:32], 29'h0} ^ 32'h5a5a_0f0f;  // Unwritten location
    endfunction

    task automatic log_command();
        $display("%0t cmd %s ba=%h ma=%h", $time, ca.name(), ba, ma);
        case (ca)
            dram_ctrl_pkg::CMD_MRW:
                if (!init_done) mrw_seen++;
            dram_ctrl_pkg::CMD_PRECHARGE: begin
                if (!init_done) begin
                    pre_seen++;
                end else if (cyc != done_cyc + 1) begin
                    errors++;
                    $display("PRECHARGE at %0t did not follow the final transfer", $time);
                end
                last_pre = cyc;
            end
            dram_ctrl_pkg::CMD_REFRESH: begin
                if (cyc - last_ref > `T_REFI + `T_RFC) begin
                    errors++;
                    $display("REFRESH at %0t came too late after the previous one", $time);
                end
                ref_seen++;
                last_ref = cyc;
            end
            dram_ctrl_pkg::CMD_ACTIVATE: begin
                if (cyc != last_take + 1 || cyc - last_ref <= `T_RFC || cyc - last_pre < `T_RP) begin
                    errors++;
                    $display("ACTIVATE at %0t broke the command spacing", $time);
                end
                act_ba   = ba;
                act_row  = ma;
                last_act = cyc;
            end
            dram_ctrl_pkg::CMD_WRITE, dram_ctrl_pkg::CMD_READ: begin
                if (cyc - last_act != `T_RCD) begin
                    errors++;
                    $display("Column command at %0t was not T_RCD after ACTIVATE", $time);
                end
                cas_cmd  = ca;
                cas_col  = ma[9:0];
                cas_cyc  = cyc;
                wr_beat  = 0;
                if (ca == dram_ctrl_pkg::CMD_READ)
                    rd_start = cyc + `READ_LATENCY - 1;  // Lands on the sampling cycle
            end
            default: begin
                errors++;
                $display("Unexpected command %s at %0t", ca.name(), $time);
            end
        endcase
    endtask

    // Command monitor and memory model
    always @(posedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (!cke) cke_low++;
            check_bit(dq_oe, prev_w_fire, "dq_oe after write beat");
            if (prev_w_fire) check_data(dq_out, prev_wdata, "dq_out beat");
            if (dq_oe) begin
                mem[{act_ba, act_row, cas_col, wr_beat[3:0]}] = dq_out;
                wr_beat++;
            end
            prev_w_fire = wvalid && wready;
            prev_wdata  = wdata;
            if ((awvalid && awready) || (arvalid && arready)) last_take = cyc;
            if ((bvalid && bready) || (rvalid && rready && rlast)) done_cyc = cyc;
            if (!init_done && (awready || arready)) begin
                init_done = 1'b1;
                check_bit(arready, awready, "arready rising with awready");
                if (mrw_seen != `INIT_MRW_COUNT || pre_seen != 1 || cke_low != `T_POWERUP) begin
                    errors++;
                    $display("Init sequence wrong: %0d MRW, %0d PRECHARGE, %0d CKE low cycles",
                             mrw_seen, pre_seen, cke_low);
                end
            end
            if (!cs_n) log_command();
            if (cyc >= rd_start && cyc < rd_start + `MAX_BEATS)
                dq_in <= #0.5 device_word({act_ba, act_row, cas_col, 4'(cyc - rd_start)});
        end
    end

    task automatic do_read(input logic [31:0] addr, input dram_ctrl_pkg::beat_t len);
        int beat;
        araddr  = addr;
        arlen   = len;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #0.5;
        arvalid = 1'b0;
        beat    = 0;
        rready  = (random_bits(2) != 2'b00);
        while (beat <= len) begin
            @(negedge clk);
            if (rvalid) check_bit(rlast, beat == len, "rlast position");
            if (rvalid && rready) begin
                check_data(rdata, exp_mem[{addr[30:0], dram_ctrl_pkg::beat_t'(beat)}], "read beat");
                beat++;
            end
            @(posedge clk);
            #0.5;
            rready = (random_bits(2) != 2'b00);
        end
        rready = 1'b0;
        check_cmd(cas_cmd, dram_ctrl_pkg::CMD_READ, "column command");
        check_addr(act_row, addr[30:15], cas_col, addr[14:5], act_ba, addr[4:0], "read address");
    endtask

    initial begin
        #(4 * (INIT_CYC + REF_CYC + TEST_CYC) * 4);
        $display("Run timed out before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0] addrs [4];
        dram_ctrl_pkg::beat_t lens [4];
        int refs_before;
        clk         = 0;
        rst_n       = 0;
        lfsr        = 32'd38591;
        awaddr      = '0;
        awlen       = '0;
        awvalid     = 0;
        wdata       = '0;
        wlast       = 0;
        wvalid      = 0;
        bready      = 0;
        araddr      = '0;
        arlen       = '0;
        arvalid     = 0;
        rready      = 0;
        dq_in       = '0;
        errors      = 0;
        cyc         = 0;
        last_act    = 0;
        last_pre    = -100;
        last_ref    = 0;
        last_take   = 0;
        done_cyc    = 0;
        ref_seen    = 0;
        mrw_seen    = 0;
        pre_seen    = 0;
        cke_low     = 0;
        rd_start    = -100;
        wr_beat     = 0;
        cas_cyc     = -100;
        init_done   = 0;
        prev_w_fire = 0;
        prev_wdata  = '0;
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1;
        while (!init_done) @(negedge clk);  // Init checked by the monitor

        wait_refresh_window();
        do_write(32'h1234_5678, 4'd7);
        do_read(32'h1234_5678, 4'd7);

        // Write wins when both requests arrive together
        wait_refresh_window();
        araddr  = 32'h0abc_def0;
        arlen   = 4'd3;
        arvalid = 1'b1;
        do_write(32'h0abc_def0, 4'd3);
        do_read(32'h0abc_def0, 4'd3);

        refs_before = ref_seen;
        repeat (IDLE_CYC) @(negedge clk);
        if (ref_seen - refs_before < IDLE_CYC / (`T_REFI + `T_RFC)) begin
            errors++;
            $display("Too few REFRESH commands during the idle stretch");
        end

        for (int i = 0; i < 4; i++) begin
            addrs[i] = random_bits(31);
            lens[i]  = dram_ctrl_pkg::beat_t'(random_bits(3));
            wait_refresh_window();
            do_write(addrs[i], lens[i]);
        end
        for (int i = 0; i < 4; i++) begin
            wait_refresh_window();
            do_read(addrs[i], lens[i]);
        end

        repeat (20) @(negedge clk);
        $display("Checks complete with %0d errors", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- hdl/dram_burst_path.sv
// Burst data path and command register
`timescale 1ns/1ps
`include "dram_ctrl_cfg.svh"

module dram_burst_path (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ADDR_WIDTH-1:0]   awaddr,
    input  logic [`ADDR_WIDTH-1:0]   araddr,
    input  dram_ctrl_pkg::beat_t     awlen,
    input  dram_ctrl_pkg::beat_t     arlen,
    input  dram_ctrl_pkg::dq_t       wdata,
    input  dram_ctrl_pkg::dq_t       dq_in,
    input  logic                     wvalid,
    input  logic                     rready,
    output logic                     wready,
    output logic                     rvalid,
    output logic                     rlast,
    output logic                     cs_n,
    output logic                     dq_oe,
    output dram_ctrl_pkg::dq_t       rdata,
    output dram_ctrl_pkg::dq_t       dq_out,
    output dram_ctrl_pkg::dram_cmd_e ca,
    output logic [4:0]               ba,
    output logic [15:0]              ma,
    burst_if.path                    bus
);
    logic [`ADDR_WIDTH-1:0]      req_addr;
    logic [`ADDR_WIDTH-1:0]      cur_addr;
    dram_ctrl_pkg::beat_t        req_len;
    dram_ctrl_pkg::beat_t        beat_cnt;   // Write beat, capture slot or replay slot
    dram_ctrl_pkg::row_t         row;
    dram_ctrl_pkg::col_t         col;
    dram_ctrl_pkg::bank_t        bank;
    dram_ctrl_pkg::bank_group_t  bank_group;
    dram_ctrl_pkg::dq_t          rd_buf [`MAX_BEATS];
    logic                        captured;
    logic                        capture;
    logic                        w_fire;
    logic                        r_fire;
    logic                        take;

    assign take = bus.take_write || bus.take_read;

    // ACTIVATE goes out with the address still on the request port
    assign cur_addr   = bus.take_write ? awaddr : (bus.take_read ? araddr : req_addr);
    assign bank_group = cur_addr[1:0];
    assign bank       = cur_addr[4:2];
    assign col        = cur_addr[14:5];
    assign row        = cur_addr[30:15];

    assign wready  = bus.write_phase;
    assign w_fire  = wvalid && wready;
    assign capture = bus.read_phase && !captured;
    assign rvalid  = bus.read_phase && captured;
    assign r_fire  = rvalid && rready;
    assign rlast   = rvalid && (beat_cnt == req_len);
    assign rdata   = rd_buf[beat_cnt];

    assign bus.last_beat  = (bus.write_phase || bus.read_phase) && (beat_cnt == req_len);
    assign bus.beats_done = (w_fire || r_fire) && bus.last_beat;

    always_ff @(posedge clk) begin
        if (take) begin
            req_addr <= cur_addr;
            req_len  <= bus.take_write ? awlen : arlen;
        end
        if (capture)
            rd_buf[beat_cnt] <= dq_in;
        if (w_fire)
            dq_out <= wdata;
        ba <= {bank, bank_group};
        ma <= (bus.cmd == dram_ctrl_pkg::CMD_ACTIVATE) ? row : {6'd0, col};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_n     <= 1'b1;
            ca       <= dram_ctrl_pkg::CMD_NOP;
            dq_oe    <= 1'b0;
            beat_cnt <= '0;
            captured <= 1'b0;
        end else begin
            cs_n  <= (bus.cmd == dram_ctrl_pkg::CMD_NOP);
            ca    <= bus.cmd;
            dq_oe <= w_fire;
            if (take) begin
                beat_cnt <= '0;
                captured <= 1'b0;
            end else if (capture) begin
                if (beat_cnt == req_len) begin
                    beat_cnt <= '0;  // Rewind for replay
                    captured <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end else if (w_fire || r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Sequencer closes the write phase on the final beat
    a_write_len: assert property (@(posedge clk) disable iff (!rst_n)
        (w_fire && bus.last_beat) |=> !w_fire);

    // Read channel goes quiet once the final beat is taken
    a_read_end: assert property (@(posedge clk) disable iff (!rst_n)
        (r_fire && rlast) |=> !bus.read_phase && !rvalid);

endmodule

//--- hdl/dram_ctrl_cfg.svh
// Controller timing and sizes
`ifndef DRAM_CTRL_CFG_SVH
`define DRAM_CTRL_CFG_SVH

// Request and data widths
`define ADDR_WIDTH      32
`define DQ_WIDTH        32
`define MAX_BEATS       16
`define TIMER_WIDTH     8     // Wide enough for the longest spacing

// Power-up sequence, in clk cycles
`define T_POWERUP       20    // CKE low after reset
`define T_CKE           10
`define INIT_MRW_COUNT  5
`define T_MRW           5     // Per mode register write
`define T_ZQ            50
`define T_INIT_END      50

// Command spacing
`define T_RCD           6     // ACTIVATE to WRITE or READ
`define T_RP            6
`define T_RFC           35

// Refresh interval
`define T_REFI          400

// READ command to first dq_in sample
`define READ_LATENCY    8

`endif

//--- hdl/dram_ctrl_if.sv
// Sequencer side interfaces
`timescale 1ns/1ps
`include "dram_ctrl_cfg.svh"

// Command spacing and refresh request
interface timer_if;
    logic                    load;         // Strobe, starts a countdown
    logic [`TIMER_WIDTH-1:0] delay;        // At least 1
    logic                    expired;
    logic                    refresh_due;
    logic                    refresh_ack;

    modport seq (
        output load, delay, refresh_ack,
        input  expired, refresh_due
    );

    modport tmr (
        input  load, delay, refresh_ack,
        output expired, refresh_due
    );
endinterface

// Burst control between sequencer and data path
interface burst_if;
    logic                      take_write;
    logic                      take_read;
    dram_ctrl_pkg::dram_cmd_e  cmd;          // NOP when idle
    logic                      write_phase;
    logic                      read_phase;
    logic                      last_beat;
    logic                      beats_done;   // Final beat transferred

    modport seq (
        output take_write, take_read, cmd, write_phase, read_phase,
        input  last_beat, beats_done
    );

    modport path (
        input  take_write, take_read, cmd, write_phase, read_phase,
        output last_beat, beats_done
    );
endinterface

//--- hdl/dram_ctrl_pkg.sv
// Controller types
`include "dram_ctrl_cfg.svh"

package dram_ctrl_pkg;

    // Main controller states
    typedef enum logic [3:0] {
        ST_INIT,
        ST_IDLE,
        ST_ACT,
        ST_CAS,
        ST_WRITE_DATA,
        ST_WRITE_RESP,
        ST_READ_WAIT,
        ST_READ_DATA,
        ST_PRECHARGE,
        ST_REFRESH
    } ctrl_state_e;

    typedef enum logic [2:0] {
        STEP_POWERUP,
        STEP_CKE_HIGH,
        STEP_MRW,
        STEP_ZQ_WAIT,
        STEP_PRECHARGE_ALL,
        STEP_FINAL
    } init_step_e;

    // CA opcodes
    typedef enum logic [5:0] {
        CMD_NOP       = 6'b000000,
        CMD_MRW       = 6'b000001,
        CMD_MRR       = 6'b000010,
        CMD_REFRESH   = 6'b000100,
        CMD_PRECHARGE = 6'b001000,
        CMD_ACTIVATE  = 6'b010000,
        CMD_WRITE     = 6'b100000,
        CMD_READ      = 6'b100001
    } dram_cmd_e;

    typedef logic [15:0] row_t;
    typedef logic [9:0]  col_t;
    typedef logic [2:0]  bank_t;
    typedef logic [1:0]  bank_group_t;

    typedef logic [$clog2(`MAX_BEATS)-1:0] beat_t;  // Beat index and burst length
    typedef logic [`DQ_WIDTH-1:0]          dq_t;

endpackage

//--- hdl/dram_ctrl_top.sv
// LPDDR4 controller top
`timescale 1ns/1ps
`include "dram_ctrl_cfg.svh"

module dram_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Write request, data and response
    input  logic [`ADDR_WIDTH-1:0]   awaddr,
    input  dram_ctrl_pkg::beat_t     awlen,
    input  logic                     awvalid,
    output logic                     awready,
    input  dram_ctrl_pkg::dq_t       wdata,
    input  logic                     wlast,
    input  logic                     wvalid,
    output logic                     wready,
    output logic                     bvalid,
    input  logic                     bready,
    // Read request and data
    input  logic [`ADDR_WIDTH-1:0]   araddr,
    input  dram_ctrl_pkg::beat_t     arlen,
    input  logic                     arvalid,
    output logic                     arready,
    output dram_ctrl_pkg::dq_t       rdata,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    // DRAM pins
    output logic                     cke,
    output logic                     cs_n,
    output dram_ctrl_pkg::dram_cmd_e ca,
    output logic [4:0]               ba,   // Bank in 4:2, bank group in 1:0
    output logic [15:0]              ma,
    output dram_ctrl_pkg::dq_t       dq_out,
    output logic                     dq_oe,
    input  dram_ctrl_pkg::dq_t       dq_in
);
    timer_if tmr();
    burst_if bus();

    // Port names match the local nets
    dram_sequencer dram_sequencer_inst (
        .*
    );

    dram_timer dram_timer_inst (
        .*
    );

    dram_burst_path dram_burst_path_inst (
        .*
    );

endmodule

//--- hdl/dram_sequencer.sv
// Main command sequencer
`timescale 1ns/1ps
`include "dram_ctrl_cfg.svh"

module dram_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic awvalid,
    input  logic arvalid,
    input  logic wvalid,
    input  logic wlast,
    input  logic bready,
    output logic awready,
    output logic arready,
    output logic bvalid,
    output logic cke,
    timer_if.seq tmr,
    burst_if.seq bus
);
    localparam int MRW_W = $clog2(`INIT_MRW_COUNT + 1);

    dram_ctrl_pkg::ctrl_state_e state, state_next;
    dram_ctrl_pkg::init_step_e  step, step_next;
    logic [MRW_W-1:0]           mrw_cnt, mrw_cnt_next;
    logic                       powerup_pending;  // First cycle out of reset
    logic                       cke_next;
    logic                       is_write, is_write_next;
    logic                       accept_ok;

    assign accept_ok = (state == dram_ctrl_pkg::ST_IDLE) && !tmr.refresh_due;
    assign awready   = accept_ok;
    assign arready   = accept_ok && !awvalid;  // Write wins
    assign bvalid    = (state == dram_ctrl_pkg::ST_WRITE_RESP);

    assign bus.write_phase = (state == dram_ctrl_pkg::ST_WRITE_DATA);
    assign bus.read_phase  = (state == dram_ctrl_pkg::ST_READ_WAIT) ||
                             (state == dram_ctrl_pkg::ST_READ_DATA);

    always_comb begin
        state_next      = state;
        step_next       = step;
        mrw_cnt_next    = mrw_cnt;
        cke_next        = cke;
        is_write_next   = is_write;
        tmr.load        = 1'b0;
        tmr.delay       = '0;
        tmr.refresh_ack = 1'b0;
        bus.cmd         = dram_ctrl_pkg::CMD_NOP;
        bus.take_write  = 1'b0;
        bus.take_read   = 1'b0;

        case (state)
            dram_ctrl_pkg::ST_INIT: begin
                if (powerup_pending) begin
                    tmr.load  = 1'b1;
                    tmr.delay = `TIMER_WIDTH'(`T_POWERUP - 1);  // Load cycle counts too
                end else if (tmr.expired) begin
                    // Each step launches the next one
                    case (step)
                        dram_ctrl_pkg::STEP_POWERUP: begin
                            cke_next  = 1'b1;
                            tmr.load  = 1'b1;
                            tmr.delay = `TIMER_WIDTH'(`T_CKE);
                            step_next = dram_ctrl_pkg::STEP_CKE_HIGH;
                        end
                        dram_ctrl_pkg::STEP_CKE_HIGH: begin
                            bus.cmd      = dram_ctrl_pkg::CMD_MRW;
                            tmr.load     = 1'b1;
                            tmr.delay    = `TIMER_WIDTH'(`T_MRW);
                            mrw_cnt_next = '0;
                            step_next    = dram_ctrl_pkg::STEP_MRW;
                        end
                        dram_ctrl_pkg::STEP_MRW: begin
                            tmr.load = 1'b1;
                            if (mrw_cnt == MRW_W'(`INIT_MRW_COUNT - 1)) begin
                                tmr.delay = `TIMER_WIDTH'(`T_ZQ);
                                step_next = dram_ctrl_pkg::STEP_ZQ_WAIT;
                            end else begin
                                bus.cmd      = dram_ctrl_pkg::CMD_MRW;
                                tmr.delay    = `TIMER_WIDTH'(`T_MRW);
                                mrw_cnt_next = mrw_cnt + 1'b1;
                            end
                        end
                        dram_ctrl_pkg::STEP_ZQ_WAIT: begin
                            bus.cmd   = dram_ctrl_pkg::CMD_PRECHARGE;  // All banks
                            tmr.load  = 1'b1;
                            tmr.delay = `TIMER_WIDTH'(`T_RP);
                            step_next = dram_ctrl_pkg::STEP_PRECHARGE_ALL;
                        end
                        dram_ctrl_pkg::STEP_PRECHARGE_ALL: begin
                            tmr.load  = 1'b1;
                            tmr.delay = `TIMER_WIDTH'(`T_INIT_END);
                            step_next = dram_ctrl_pkg::STEP_FINAL;
                        end
                        default: state_next = dram_ctrl_pkg::ST_IDLE;
                    endcase
                end
            end

            dram_ctrl_pkg::ST_IDLE: begin
                tmr.load = tmr.refresh_due || awvalid || arvalid;
                if (tmr.refresh_due) begin
                    bus.cmd         = dram_ctrl_pkg::CMD_REFRESH;
                    tmr.refresh_ack = 1'b1;
                    tmr.delay       = `TIMER_WIDTH'(`T_RFC);
                    state_next      = dram_ctrl_pkg::ST_REFRESH;
                end else if (awvalid || arvalid) begin
                    bus.take_write = awvalid;
                    bus.take_read  = !awvalid;
                    is_write_next  = awvalid;
                    bus.cmd        = dram_ctrl_pkg::CMD_ACTIVATE;
                    tmr.delay      = `TIMER_WIDTH'(`T_RCD);
                    state_next     = dram_ctrl_pkg::ST_ACT;
                end
            end

            dram_ctrl_pkg::ST_ACT: begin
                if (tmr.expired) begin
                    bus.cmd    = is_write ? dram_ctrl_pkg::CMD_WRITE : dram_ctrl_pkg::CMD_READ;
                    tmr.load   = !is_write;
                    tmr.delay  = `TIMER_WIDTH'(`READ_LATENCY);
                    state_next = dram_ctrl_pkg::ST_CAS;
                end
            end

            // Timer stays at zero for writes
            dram_ctrl_pkg::ST_CAS:
                if (tmr.expired)
                    state_next = is_write ? dram_ctrl_pkg::ST_WRITE_DATA
                                          : dram_ctrl_pkg::ST_READ_WAIT;

            dram_ctrl_pkg::ST_WRITE_DATA:
                if ((wvalid && wlast) || bus.beats_done)
                    state_next = dram_ctrl_pkg::ST_WRITE_RESP;

            dram_ctrl_pkg::ST_READ_WAIT:
                if (bus.last_beat)
                    state_next = dram_ctrl_pkg::ST_READ_DATA;  // Final sample this cycle

            dram_ctrl_pkg::ST_WRITE_RESP, dram_ctrl_pkg::ST_READ_DATA: begin
                if (bvalid ? bready : bus.beats_done) begin
                    bus.cmd    = dram_ctrl_pkg::CMD_PRECHARGE;
                    tmr.load   = 1'b1;
                    tmr.delay  = `TIMER_WIDTH'(`T_RP);
                    state_next = dram_ctrl_pkg::ST_PRECHARGE;
                end
            end

            dram_ctrl_pkg::ST_PRECHARGE, dram_ctrl_pkg::ST_REFRESH:
                if (tmr.expired)
                    state_next = dram_ctrl_pkg::ST_IDLE;

            default: state_next = dram_ctrl_pkg::ST_INIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= dram_ctrl_pkg::ST_INIT;
            step            <= dram_ctrl_pkg::STEP_POWERUP;
            mrw_cnt         <= '0;
            powerup_pending <= 1'b1;
            cke             <= 1'b0;
            is_write        <= 1'b0;
        end else begin
            state           <= state_next;
            step            <= step_next;
            mrw_cnt         <= mrw_cnt_next;
            powerup_pending <= 1'b0;
            cke             <= cke_next;
            is_write        <= is_write_next;
        end
    end

    // Requests only accepted once the init sequence has finished
    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (awready || arready) |-> cke && (step == dram_ctrl_pkg::STEP_FINAL));

    // A new spacing never cuts a running one short
    a_load_expired: assert property (@(posedge clk) disable iff (!rst_n)
        tmr.load |-> tmr.expired);

endmodule

//--- hdl/dram_timer.sv
// Command spacing and refresh timers
`timescale 1ns/1ps
`include "dram_ctrl_cfg.svh"

module dram_timer (
    input  logic clk,
    input  logic rst_n,
    timer_if.tmr tmr
);
    localparam int REFI_W = $clog2(`T_REFI + 1);

    logic [`TIMER_WIDTH-1:0] count;
    logic [REFI_W-1:0]       refi_cnt;

    // Reaches zero delay cycles after the load strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (tmr.load) begin
            count <= tmr.delay - 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign tmr.expired = (count == '0);

    // Saturates until the sequencer issues REFRESH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refi_cnt <= '0;
        end else if (tmr.refresh_ack) begin
            refi_cnt <= '0;
        end else if (refi_cnt != REFI_W'(`T_REFI)) begin
            refi_cnt <= refi_cnt + 1'b1;
        end
    end

    assign tmr.refresh_due = (refi_cnt == REFI_W'(`T_REFI));

    // Bursts in flight may delay refresh, but not past one extra interval
    a_refresh_served: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tmr.refresh_due) |-> ##[0:`T_RFC + `T_REFI] tmr.refresh_ack);

endmodule

//--- list.f
+incdir+hdl
+incdir+bench
hdl/dram_ctrl_pkg.sv
hdl/dram_ctrl_if.sv
hdl/dram_timer.sv
hdl/dram_sequencer.sv
hdl/dram_burst_path.sv
hdl/dram_ctrl_top.sv
bench/tb_dram_ctrl.sv
